//--- dma_config.svh
`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

// ----------------------------------------
// Bus and transfer geometry
// ----------------------------------------

// Byte address width on both buses
`define DMA_ADDR_WIDTH 24

// Bus word width in bits, shared by AXI and OBI
`define DMA_DATA_WIDTH 32

// Transfer length in bytes
`define DMA_LEN_WIDTH 16

// AXI page, no read burst may cross it
`define DMA_PAGE_SIZE 4096

`endif

//--- dma_pkg.sv
`include "dma_config.svh"

package dma_pkg;

    // ----------------------------------------
    // Derived widths
    // ----------------------------------------
    localparam int unsigned ADDR_WIDTH       = `DMA_ADDR_WIDTH;
    localparam int unsigned LEN_WIDTH        = `DMA_LEN_WIDTH;
    // Bytes per bus word
    localparam int unsigned STRB_WIDTH       = `DMA_DATA_WIDTH / 8;
    // Byte offset inside a bus word
    localparam int unsigned OFFSET_WIDTH     = $clog2(STRB_WIDTH);
    localparam int unsigned PAGE_ADDR_WIDTH  = $clog2(`DMA_PAGE_SIZE);
    // One extra bit so a full page still fits
    localparam int unsigned PAGE_LEN_WIDTH   = PAGE_ADDR_WIDTH + 1;
    // AXI len is 8 bits, so 256 beats at most
    localparam int unsigned MAX_BURST_BYTES  = 256 * STRB_WIDTH;
    // Read split grid, the smaller of page and longest burst
    localparam int unsigned SPLIT_BYTES      = (MAX_BURST_BYTES < `DMA_PAGE_SIZE) ?
                                               MAX_BURST_BYTES : `DMA_PAGE_SIZE;
    localparam int unsigned SPLIT_ADDR_WIDTH = $clog2(SPLIT_BYTES);

    typedef logic [ADDR_WIDTH-1:0]     addr_t;
    typedef logic [LEN_WIDTH-1:0]      len_t;
    typedef logic [OFFSET_WIDTH-1:0]   offset_t;
    typedef logic [PAGE_LEN_WIDTH-1:0] page_len_t;
    typedef logic [STRB_WIDTH-1:0]     strb_t;

    // ----------------------------------------
    // Encodings
    // ----------------------------------------
    // AXI burst type, same codes as on the bus
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } dma_burst_e;

    typedef enum logic {
        IDLE     = 1'b0,
        WAIT_GNT = 1'b1
    } dma_wstate_e;

    // ----------------------------------------
    // Payloads
    // ----------------------------------------
    // One 1D transfer from the front end
    typedef struct packed {
        len_t       length;
        addr_t      src_addr;
        addr_t      dst_addr;
        dma_burst_e burst;
        logic       src_reduce_len;
        // log2 of beats per burst when reducing
        logic [2:0] src_max_llen;
        logic       last;
    } dma_req_t;

    // AXI read address beat, addr is word aligned
    typedef struct packed {
        addr_t      addr;
        logic [7:0] len;
        logic [2:0] size;
        dma_burst_e burst;
    } dma_ar_t;

    // One write word toward the OBI port
    typedef struct packed {
        addr_t                 addr;
        offset_t               offset;
        logic [OFFSET_WIDTH:0] num_bytes;
        logic                  last;
    } dma_wword_t;

    typedef struct packed {
        addr_t addr;
        logic  we;
        strb_t be;
    } dma_obi_req_t;

endpackage

//--- dma_page_splitter.sv
module dma_page_splitter import dma_pkg::*; (
    input  addr_t      addr_i,
    input  logic       word_mode_i,
    input  logic       reduce_len_i,
    input  logic [2:0] max_llen_i,
    output page_len_t  bytes_to_bound_o
);
    // Distances to each candidate boundary
    page_len_t word_bytes;
    page_len_t page_bytes;
    page_len_t base_bytes;
    // Span of a beat-limited burst in bytes
    page_len_t llen_span;
    page_len_t llen_bytes;

    // ----------------------------------------
    // Natural boundaries
    // ----------------------------------------
    // Word mode, bytes left in the current bus word
    assign word_bytes = page_len_t'(STRB_WIDTH) - page_len_t'(addr_i[OFFSET_WIDTH-1:0]);

    // Page mode, bytes left on the split grid
    assign page_bytes = page_len_t'(SPLIT_BYTES) - page_len_t'(addr_i[SPLIT_ADDR_WIDTH-1:0]);

    assign base_bytes = word_mode_i ? word_bytes : page_bytes;

    // ----------------------------------------
    // Burst length reduction
    // ----------------------------------------
    // 2^max_llen beats of one bus word each
    assign llen_span = page_len_t'(STRB_WIDTH) << max_llen_i;

    // Distance to the next multiple of the span
    // aligned address gives a whole span
    assign llen_bytes = llen_span
                      - (page_len_t'(addr_i[PAGE_ADDR_WIDTH-1:0]) & (llen_span - 1'b1));

    // Closer boundary wins
    always_comb begin
        if (reduce_len_i && (llen_bytes < base_bytes)) begin
            bytes_to_bound_o = llen_bytes;
        end else begin
            bytes_to_bound_o = base_bytes;
        end
    end

endmodule

//--- dma_legalizer.sv
module dma_legalizer import dma_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  dma_req_t   req_i,
    input  logic       valid_i,
    output logic       ready_o,
    input  logic       kill_i,
    output dma_ar_t    ar_o,
    output logic       ar_valid_o,
    input  logic       ar_ready_i,
    output dma_wword_t wword_o,
    output logic       wword_valid_o,
    input  logic       wword_ready_i,
    output logic       r_busy_o,
    output logic       w_busy_o
);
    // Mutable state of one side of the transfer
    typedef struct packed {
        addr_t addr;
        len_t  length;
        logic  busy;
    } side_t;

    // Options latched with the request
    typedef struct packed {
        dma_burst_e burst;
        logic       reduce_len;
        logic [2:0] max_llen;
    } opt_t;

    side_t     r_q, r_d;
    side_t     w_q, w_d;
    opt_t      opt_q;
    // Low during reset, holds ready_o off
    logic      live_q;

    // Splitter results
    page_len_t r_bound;
    page_len_t w_bound;

    // Piece issued this cycle
    page_len_t r_num;
    page_len_t w_num;
    page_len_t r_span;
    logic      r_last;
    logic      w_last;

    logic      accept;
    logic      r_step;
    logic      w_step;

    // ----------------------------------------
    // Boundary checks
    // ----------------------------------------
    // Read side on the page grid with optional reduction
    dma_page_splitter i_read_splitter (
        .addr_i           ( r_q.addr         ),
        .word_mode_i      ( 1'b0             ),
        .reduce_len_i     ( opt_q.reduce_len ),
        .max_llen_i       ( opt_q.max_llen   ),
        .bytes_to_bound_o ( r_bound          )
    );

    // OBI words never span two bus words
    dma_page_splitter i_write_splitter (
        .addr_i           ( w_q.addr ),
        .word_mode_i      ( 1'b1     ),
        .reduce_len_i     ( 1'b0     ),
        .max_llen_i       ( 3'd0     ),
        .bytes_to_bound_o ( w_bound  )
    );

    // ----------------------------------------
    // Piece sizing
    // ----------------------------------------
    // Smaller of remainder and bound
    always_comb begin
        if (r_q.length > len_t'(r_bound)) begin
            r_num  = r_bound;
            r_last = 1'b0;
        end else begin
            r_num  = r_q.length[PAGE_LEN_WIDTH-1:0];
            r_last = 1'b1;
        end
    end

    always_comb begin
        if (w_q.length > len_t'(w_bound)) begin
            w_num  = w_bound;
            w_last = 1'b0;
        end else begin
            w_num  = w_q.length[PAGE_LEN_WIDTH-1:0];
            w_last = 1'b1;
        end
    end

    // ----------------------------------------
    // Handshakes and next state
    // ----------------------------------------
    // New transfer only when both machines are idle
    assign ready_o = live_q && !r_q.busy && !w_q.busy;
    assign accept  = ready_o && valid_i;
    assign r_step  = ar_valid_o && ar_ready_i;
    assign w_step  = wword_valid_o && wword_ready_i;

    always_comb begin
        r_d = r_q;
        w_d = w_q;

        // Advance each side on its own handshake
        if (r_step) begin
            r_d.addr   = r_q.addr + addr_t'(r_num);
            r_d.length = r_q.length - len_t'(r_num);
            r_d.busy   = !r_last;
        end
        if (w_step) begin
            w_d.addr   = w_q.addr + addr_t'(w_num);
            w_d.length = w_q.length - len_t'(w_num);
            w_d.busy   = !w_last;
        end

        // Kill drops whatever is left
        if (kill_i) begin
            r_d.busy = 1'b0;
            w_d.busy = 1'b0;
        end

        // Load both sides from the request
        // zero length leaves them idle
        if (accept) begin
            r_d = '{addr: req_i.src_addr, length: req_i.length, busy: |req_i.length};
            w_d = '{addr: req_i.dst_addr, length: req_i.length, busy: |req_i.length};
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            r_q    <= '0;
            w_q    <= '0;
            live_q <= 1'b0;
        end else begin
            r_q    <= r_d;
            w_q    <= w_d;
            live_q <= 1'b1;
        end
    end

    // Burst options of the current transfer
    always_ff @(posedge clk_i) begin
        if (accept) begin
            opt_q <= '{
                burst:      req_i.burst,
                reduce_len: req_i.src_reduce_len,
                max_llen:   req_i.src_max_llen
            };
        end
    end

    // ----------------------------------------
    // Outputs
    // ----------------------------------------
    // Bytes covered from the aligned start including the offset
    assign r_span = r_num + page_len_t'(r_q.addr[OFFSET_WIDTH-1:0]) - 1'b1;

    assign ar_valid_o = r_q.busy;
    assign ar_o = '{
        addr:  {r_q.addr[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}},
        len:   8'(r_span >> OFFSET_WIDTH),
        size:  3'(OFFSET_WIDTH),
        burst: opt_q.burst
    };

    assign wword_valid_o = w_q.busy;
    assign wword_o = '{
        addr:      {w_q.addr[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}},
        offset:    w_q.addr[OFFSET_WIDTH-1:0],
        num_bytes: w_num[OFFSET_WIDTH:0],
        last:      w_last
    };

    assign r_busy_o = r_q.busy;
    assign w_busy_o = w_q.busy;

    // ----------------------------------------
    // Assertions
    // ----------------------------------------
    // Only incrementing bursts can be split
    a_incr_only: assert property (@(posedge clk_i) disable iff (reset_i)
        accept |-> (req_i.burst == INCR));

endmodule

//--- dma_obi_write_port.sv
module dma_obi_write_port import dma_pkg::*; (
    input  logic         clk_i,
    input  logic         reset_i,
    input  dma_wword_t   wword_i,
    input  logic         wword_valid_i,
    output logic         wword_ready_o,
    output dma_obi_req_t obi_req_o,
    output logic         obi_req_valid_o,
    input  logic         obi_gnt_i,
    output logic         done_o
);
    dma_wstate_e  state_q, state_d;
    // Held request and its end-of-transfer flag
    dma_obi_req_t req_q;
    logic         last_q;
    strb_t        be;
    logic         take;

    // ----------------------------------------
    // Byte enables
    // ----------------------------------------
    // Lanes from offset up to offset plus count
    always_comb begin
        for (int i = 0; i < STRB_WIDTH; i++) begin
            be[i] = (i >= int'(wword_i.offset))
                 && (i < int'(wword_i.offset) + int'(wword_i.num_bytes));
        end
    end

    // ----------------------------------------
    // Request FSM
    // ----------------------------------------
    // One word in flight, taken only when idle
    assign wword_ready_o = (state_q == IDLE);
    assign take          = wword_ready_o && wword_valid_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (take) begin
                    state_d = WAIT_GNT;
                end
            end
            WAIT_GNT: begin
                // Hold until the slave grants
                if (obi_gnt_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Payload capture
    always_ff @(posedge clk_i) begin
        if (take) begin
            req_q  <= '{addr: wword_i.addr, we: 1'b1, be: be};
            last_q <= wword_i.last;
        end
    end

    assign obi_req_o       = req_q;
    assign obi_req_valid_o = (state_q == WAIT_GNT);

    // Grant of the final word ends the transfer
    assign done_o = obi_req_valid_o && obi_gnt_i && last_q;

    // ----------------------------------------
    // Assertions
    // ----------------------------------------
    a_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        (obi_req_valid_o && !obi_gnt_i) |=> (obi_req_valid_o && $stable(obi_req_o)));

endmodule

//--- dma_backend_top.sv
module dma_backend_top import dma_pkg::*; (
    input  logic         clk_i,
    input  logic         reset_i,
    // Front end
    input  dma_req_t     req_i,
    input  logic         valid_i,
    output logic         ready_o,
    input  logic         kill_i,
    // AXI read address
    output dma_ar_t      ar_o,
    output logic         ar_valid_o,
    input  logic         ar_ready_i,
    // OBI write request
    output dma_obi_req_t obi_req_o,
    output logic         obi_req_valid_o,
    input  logic         obi_gnt_i,
    // Status
    output logic         r_busy_o,
    output logic         w_busy_o,
    output logic         done_o
);
    // Legalizer to write port
    dma_wword_t wword;
    logic       wword_valid;
    logic       wword_ready;

    // ----------------------------------------
    // Transfer splitting
    // ----------------------------------------
    dma_legalizer i_legalizer (
        .clk_i         ( clk_i       ),
        .reset_i       ( reset_i     ),
        .req_i         ( req_i       ),
        .valid_i       ( valid_i     ),
        .ready_o       ( ready_o     ),
        .kill_i        ( kill_i      ),
        .ar_o          ( ar_o        ),
        .ar_valid_o    ( ar_valid_o  ),
        .ar_ready_i    ( ar_ready_i  ),
        .wword_o       ( wword       ),
        .wword_valid_o ( wword_valid ),
        .wword_ready_i ( wword_ready ),
        .r_busy_o      ( r_busy_o    ),
        .w_busy_o      ( w_busy_o    )
    );

    // ----------------------------------------
    // OBI write side
    // ----------------------------------------
    dma_obi_write_port i_obi_write_port (
        .clk_i           ( clk_i           ),
        .reset_i         ( reset_i         ),
        .wword_i         ( wword           ),
        .wword_valid_i   ( wword_valid     ),
        .wword_ready_o   ( wword_ready     ),
        .obi_req_o       ( obi_req_o       ),
        .obi_req_valid_o ( obi_req_valid_o ),
        .obi_gnt_i       ( obi_gnt_i       ),
        .done_o          ( done_o          )
    );

endmodule

//--- tb_dma_backend.sv
`include "dma_config.svh"

module tb_dma_backend import dma_pkg::*; ();

    localparam int unsigned WORD_BYTES  = `DMA_DATA_WIDTH / 8;
    localparam int unsigned PAGE_BYTES  = `DMA_PAGE_SIZE;
    // Bytes over all tests with the killed transfer counted in full
    localparam int unsigned TOTAL_BYTES = 195;
    localparam int unsigned MAX_CYCLES  = TOTAL_BYTES * 4 + 500;
    // Ready and grant patterns
    localparam int BP_OPEN   = 0;
    localparam int BP_RANDOM = 1;
    localparam int BP_STALL  = 2;

    logic         clk;
    logic         reset_i;
    dma_req_t     req_i;
    logic         valid_i;
    logic         ready_o;
    logic         kill_i;
    dma_ar_t      ar_o;
    logic         ar_valid_o;
    logic         ar_ready_i;
    dma_obi_req_t obi_req_o;
    logic         obi_req_valid_o;
    logic         obi_gnt_i;
    logic         r_busy_o;
    logic         w_busy_o;
    logic         done_o;

    // Expected bus traffic in issue order
    dma_ar_t      ar_exp[$];
    dma_obi_req_t obi_exp[$];
    int           errors;
    int           done_count;
    int           cycles;
    int           bp_mode;
    logic         reduce_check;
    logic [31:0]  lcg_state;

    dma_backend_top dut (
        .clk_i           ( clk             ),
        .reset_i         ( reset_i         ),
        .req_i           ( req_i           ),
        .valid_i         ( valid_i         ),
        .ready_o         ( ready_o         ),
        .kill_i          ( kill_i          ),
        .ar_o            ( ar_o            ),
        .ar_valid_o      ( ar_valid_o      ),
        .ar_ready_i      ( ar_ready_i      ),
        .obi_req_o       ( obi_req_o       ),
        .obi_req_valid_o ( obi_req_valid_o ),
        .obi_gnt_i       ( obi_gnt_i       ),
        .r_busy_o        ( r_busy_o        ),
        .w_busy_o        ( w_busy_o        ),
        .done_o          ( done_o          )
    );

    always #50 clk = ~clk;

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Upper LCG bits are the least regular
    always @(posedge clk) begin
        logic [31:0] rnd;
        case (bp_mode)
            BP_RANDOM: begin
                rnd = lcg_next();
                ar_ready_i <= rnd[30];
                obi_gnt_i  <= rnd[27];
            end
            BP_STALL: begin
                ar_ready_i <= 1'b0;
                obi_gnt_i  <= 1'b0;
            end
            default: begin
                ar_ready_i <= 1'b1;
                obi_gnt_i  <= 1'b1;
            end
        endcase
    end

    function automatic dma_req_t make_req(input int unsigned len, input int unsigned src,
                                          input int unsigned dst, input logic reduce,
                                          input logic [2:0] llen);
        dma_req_t r;
        r.length         = len_t'(len);
        r.src_addr       = addr_t'(src);
        r.dst_addr       = addr_t'(dst);
        r.burst          = INCR;
        r.src_reduce_len = reduce;
        r.src_max_llen   = llen;
        r.last           = 1'b1;
        return r;
    endfunction

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    // AR bursts cut at the page and at the beat limit
    task automatic model_reads(input dma_req_t r);
        int unsigned addr;
        int unsigned rem;
        int unsigned bound;
        int unsigned span;
        int unsigned n;
        dma_ar_t     ar;
        addr = r.src_addr;
        rem  = r.length;
        while (rem > 0) begin
            bound = PAGE_BYTES - addr % PAGE_BYTES;
            if (r.src_reduce_len) begin
                span = WORD_BYTES << r.src_max_llen;
                if (span - addr % span < bound) begin
                    bound = span - addr % span;
                end
            end
            n = (rem < bound) ? rem : bound;
            // Beats counted from the aligned start
            ar.addr  = addr_t'(addr - addr % WORD_BYTES);
            ar.len   = 8'((n + addr % WORD_BYTES - 1) / WORD_BYTES);
            ar.size  = 3'($clog2(WORD_BYTES));
            ar.burst = INCR;
            ar_exp.push_back(ar);
            addr += n;
            rem  -= n;
        end
    endtask

    // One OBI word per bus word touched
    task automatic model_writes(input dma_req_t r);
        int unsigned  addr;
        int unsigned  rem;
        int unsigned  off;
        int unsigned  n;
        dma_obi_req_t wr;
        addr = r.dst_addr;
        rem  = r.length;
        while (rem > 0) begin
            off     = addr % WORD_BYTES;
            n       = (rem < WORD_BYTES - off) ? rem : WORD_BYTES - off;
            wr.addr = addr_t'(addr - off);
            wr.we   = 1'b1;
            wr.be   = strb_t'(((1 << n) - 1) << off);
            obi_exp.push_back(wr);
            addr += n;
            rem  -= n;
        end
    endtask

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic check_ar(input dma_ar_t got, input dma_ar_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: ar_o got addr=%h len=%0d size=%0d burst=%0d, %s",
                     $time, got.addr, got.len, got.size, got.burst,
                     $sformatf("expected addr=%h len=%0d size=%0d burst=%0d",
                               exp.addr, exp.len, exp.size, exp.burst));
        end
    endtask

    task automatic check_obi(input dma_obi_req_t got, input dma_obi_req_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: obi_req_o got addr=%h we=%b be=%b, %s",
                     $time, got.addr, got.we, got.be,
                     $sformatf("expected addr=%h we=%b be=%b", exp.addr, exp.we, exp.be));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("Error at %0t: %s got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %b, expected %b", $time, name, got, exp);
        end
    endtask

    // ----------------------------------------
    // Monitor and watchdog
    // ----------------------------------------
    // Handshakes sampled mid-cycle complete on the next edge
    always @(negedge clk) begin
        if (!reset_i) begin
            if (ar_valid_o && ar_ready_i) begin
                if (ar_exp.size() == 0) begin
                    errors++;
                    $display("AR burst to %h at %0t was not expected", ar_o.addr, $time);
                end else begin
                    check_ar(ar_o, ar_exp.pop_front());
                end
                if (reduce_check && ar_o.len > 8'd1) begin
                    errors++;
                    $display("Error at %0t: ar_o.len got %0d, expected at most 1",
                             $time, ar_o.len);
                end
            end
            if (obi_req_valid_o && obi_gnt_i) begin
                if (obi_exp.size() == 0) begin
                    errors++;
                    $display("OBI write to %h at %0t was not expected", obi_req_o.addr, $time);
                end else begin
                    check_obi(obi_req_o, obi_exp.pop_front());
                end
            end
            if (done_o) begin
                done_count++;
            end
            if (ready_o && (r_busy_o || w_busy_o)) begin
                errors++;
                $display("ready_o was high at %0t while a machine was busy", $time);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles, %0d errors so far",
                     MAX_CYCLES, errors);
            $display("tests failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic send_req(input dma_req_t r);
        @(posedge clk);
        req_i   <= r;
        valid_i <= 1'b1;
        do begin
            @(negedge clk);
        end while (!ready_o);
        @(posedge clk);
        valid_i <= 1'b0;
    endtask

    // Both queues empty and nothing left in flight
    task automatic wait_drain();
        do begin
            @(negedge clk);
        end while (ar_exp.size() != 0 || obi_exp.size() != 0
                   || r_busy_o || w_busy_o || obi_req_valid_o);
    endtask

    task automatic run_transfer(input dma_req_t r, input string name);
        done_count = 0;
        model_reads(r);
        model_writes(r);
        send_req(r);
        wait_drain();
        check_count({name, " done_o pulses"}, done_count, 1);
    endtask

    task automatic check_reset();
        @(posedge clk);
        @(negedge clk);
        check_flag("ready_o in reset", ready_o, 1'b0);
        check_flag("ar_valid_o in reset", ar_valid_o, 1'b0);
        check_flag("obi_req_valid_o in reset", obi_req_valid_o, 1'b0);
        check_flag("r_busy_o in reset", r_busy_o, 1'b0);
        check_flag("w_busy_o in reset", w_busy_o, 1'b0);
        check_flag("done_o in reset", done_o, 1'b0);
        @(posedge clk);
        reset_i <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_flag("ready_o after reset", ready_o, 1'b1);
    endtask

    task automatic test_aligned();
        run_transfer(make_req(16, 'h001000, 'h002000, 1'b0, 3'd0), "aligned");
    endtask

    // Starts 8 bytes below a page boundary
    task automatic test_page_cross();
        run_transfer(make_req(16, 'h000ff8, 'h003000, 1'b0, 3'd0), "page cross");
    endtask

    task automatic test_unaligned();
        run_transfer(make_req(13, 'h000103, 'h002006, 1'b0, 3'd0), "unaligned");
    endtask

    task automatic test_reduce();
        reduce_check = 1'b1;
        run_transfer(make_req(30, 'h000202, 'h004001, 1'b1, 3'd1), "reduce");
        reduce_check = 1'b0;
    endtask

    task automatic test_backpressure();
        bp_mode <= BP_RANDOM;
        run_transfer(make_req(40, 'h000401, 'h005003, 1'b0, 3'd0), "backpressure");
        bp_mode <= BP_OPEN;
    endtask

    task automatic test_kill();
        dma_obi_req_t held;
        // First word is already inside the write port
        held.addr = 'h006000;
        held.we   = 1'b1;
        held.be   = '1;
        done_count = 0;
        bp_mode <= BP_STALL;
        obi_exp.push_back(held);
        send_req(make_req(64, 'h000800, 'h006000, 1'b0, 3'd0));
        do begin
            @(negedge clk);
        end while (!obi_req_valid_o);
        @(posedge clk);
        kill_i <= 1'b1;
        @(posedge clk);
        kill_i <= 1'b0;
        @(negedge clk);
        check_flag("r_busy_o after kill", r_busy_o, 1'b0);
        check_flag("w_busy_o after kill", w_busy_o, 1'b0);
        bp_mode <= BP_OPEN;
        wait_drain();
        // Quiet bus expected for a while
        repeat (4) @(negedge clk);
        check_count("kill done_o pulses", done_count, 0);
        run_transfer(make_req(16, 'h000a02, 'h006001, 1'b0, 3'd0), "after kill");
    endtask

    initial begin
        clk          = 1'b0;
        reset_i      = 1'b1;
        req_i        = '0;
        valid_i      = 1'b0;
        kill_i       = 1'b0;
        ar_ready_i   = 1'b0;
        obi_gnt_i    = 1'b0;
        errors       = 0;
        done_count   = 0;
        cycles       = 0;
        bp_mode      = BP_OPEN;
        reduce_check = 1'b0;
        lcg_state    = 32'd49;

        check_reset();
        test_aligned();
        test_page_cross();
        test_unaligned();
        test_reduce();
        test_backpressure();
        test_kill();

        $display("Run finished after %0d cycles with %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+.
dma_pkg.sv
dma_page_splitter.sv
dma_legalizer.sv
dma_obi_write_port.sv
dma_backend_top.sv
tb_dma_backend.sv

//--- Makefile
# Verilator simulation of the DMA back-end slice
VERILATOR ?= verilator
TOP       ?= tb_dma_backend
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for a failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Overridable: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "tests failed" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	elif ! grep -q "all tests passed" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
